// ==== include/exe_macros.svh ====
`ifndef EXE_MACROS_SVH
`define EXE_MACROS_SVH

// data path width
`define XLEN 32

// register file index
`define REG_ADDR_W 5

// offset inside one sram bank
`define SRAM_ADDR_SIZE 13

// bank select sits just above the offset
`define SRAM_BANK_W 2

// address bits left above bank and offset
`define SRAM_UNUSED_W (`XLEN - `SRAM_BANK_W - `SRAM_ADDR_SIZE)

// imem address width sent back to fetch
`define BR_ADDR_W 12

// link address distance for jal and jalr
`define PC_STEP 4

`endif

// ==== src/exe_op_pkg.sv ====
`include "exe_macros.svh"

package exe_op_pkg;

    typedef enum logic [3:0] {
        ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR,
        ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_AUIPC, ALU_LINK
    } alu_op_e;

    // nine codes, so four bits
    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } br_op_e;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    typedef struct packed {
        alu_op_e                alu_op;
        br_op_e                 br_op;
        mem_op_e                mem_op;
        logic                   wb_vld;
        logic [`REG_ADDR_W-1:0] wb_addr;
        logic [`XLEN-1:0]       src1;
        logic [`XLEN-1:0]       src2;
        // branch or store offset
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       pc;
    } exe_issue_t;

    // writeback forwarded to decode
    typedef struct packed {
        logic                   vld;
        logic                   ld;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       data;
    } exe_fwd_t;

    typedef struct packed {
        logic [`XLEN-1:0] wb_data;
        logic [`XLEN-1:0] mem_addr;
        logic             is_branch_op;
    } exe_result_t;

    function automatic logic is_load(input mem_op_e op);
        return op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
    endfunction

    function automatic logic is_store(input mem_op_e op);
        return op inside {MEM_SB, MEM_SH, MEM_SW};
    endfunction

    // conditional branches only, jumps still write back
    function automatic logic is_cond_branch(input br_op_e op);
        return op inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
    endfunction

endpackage

// ==== src/exe_mem_pkg.sv ====
`include "exe_macros.svh"

package exe_mem_pkg;

    typedef enum logic [`SRAM_BANK_W-1:0] {
        BANK_IRAM = 2'b00,
        BANK_ORAM = 2'b01,
        BANK_WRAM = 2'b10,
        BANK_NONE = 2'b11
    } sram_bank_e;

    typedef struct packed {
        logic [`SRAM_UNUSED_W-1:0]  unused;
        sram_bank_e                 bank;
        logic [`SRAM_ADDR_SIZE-1:0] offset;
    } sram_addr_fields_t;

    // same word, seen raw or split into bank and offset
    typedef union packed {
        logic [`XLEN-1:0]  raw;
        sram_addr_fields_t fields;
    } sram_addr_u;

    typedef struct packed {
        logic                       wb_vld;
        logic [`REG_ADDR_W-1:0]     wb_addr;
        logic [`XLEN-1:0]           wb_data;
        exe_op_pkg::mem_op_e        mem_op;
        sram_bank_e                 bank;
        logic [`SRAM_ADDR_SIZE-1:0] offset;
        logic [`XLEN-1:0]           st_data;
    } exe_lsu_req_t;

endpackage

// ==== src/exe_int_alu.sv ====
`timescale 1ns/10ps
`include "exe_macros.svh"

module exe_int_alu
    import exe_op_pkg::*;
(
    input  exe_issue_t  issue,
    output exe_result_t result
);

    localparam int SHAMT_W = $clog2(`XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic [`XLEN-1:0]   sum;
    logic [`XLEN-1:0]   diff;
    logic [`XLEN-1:0]   sra_rlt;
    logic [`XLEN-1:0]   st_addr;
    logic               lt_s;
    logic               lt_u;
    logic [`XLEN-1:0]   alu_mux;
    logic [`XLEN-1:0]   mem_addr;

    assign shamt   = issue.src2[SHAMT_W-1:0];
    assign sum     = issue.src1 + issue.src2;
    assign diff    = issue.src1 - issue.src2;
    assign lt_s    = $signed(issue.src1) < $signed(issue.src2);
    assign lt_u    = issue.src1 < issue.src2;
    assign sra_rlt = $signed(issue.src1) >>> shamt;
    assign st_addr = issue.src1 + issue.imm;

    always_comb begin
        unique case (issue.alu_op)
            ALU_ADD:   alu_mux = sum;
            ALU_SUB:   alu_mux = diff;
            ALU_SLT:   alu_mux = {{(`XLEN-1){1'b0}}, lt_s};
            ALU_SLTU:  alu_mux = {{(`XLEN-1){1'b0}}, lt_u};
            ALU_XOR:   alu_mux = issue.src1 ^ issue.src2;
            ALU_OR:    alu_mux = issue.src1 | issue.src2;
            ALU_AND:   alu_mux = issue.src1 & issue.src2;
            ALU_SLL:   alu_mux = issue.src1 << shamt;
            ALU_SRL:   alu_mux = issue.src1 >> shamt;
            ALU_SRA:   alu_mux = sra_rlt;
            // upper immediate arrives already shifted in src2
            ALU_LUI:   alu_mux = issue.src2;
            ALU_AUIPC: alu_mux = issue.pc + issue.src2;
            ALU_LINK:  alu_mux = issue.pc + `PC_STEP;
            default:   alu_mux = '0;
        endcase
    end

    // loads index by register, stores by immediate
    always_comb begin
        if (is_load(issue.mem_op)) begin
            mem_addr = sum;
        end else if (is_store(issue.mem_op)) begin
            mem_addr = st_addr;
        end else begin
            mem_addr = '0;
        end
    end

    assign result.wb_data      = alu_mux;
    assign result.mem_addr     = mem_addr;
    assign result.is_branch_op = is_cond_branch(issue.br_op);

endmodule

// ==== src/exe_branch.sv ====
`timescale 1ns/10ps
`include "exe_macros.svh"

module exe_branch
    import exe_op_pkg::*;
(
    input  exe_issue_t       issue,
    output logic             taken,
    output logic [`XLEN-1:0] target
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = issue.src1 == issue.src2;
    assign lt_s = $signed(issue.src1) < $signed(issue.src2);
    assign lt_u = issue.src1 < issue.src2;

    always_comb begin
        unique case (issue.br_op)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = ~eq;
            BR_BLT:  taken = lt_s;
            BR_BGE:  taken = ~lt_s;
            BR_BLTU: taken = lt_u;
            BR_BGEU: taken = ~lt_u;
            BR_JAL,
            BR_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        unique case (issue.br_op)
            BR_JAL:  target = issue.pc + issue.src2;
            BR_JALR: target = issue.src1 + issue.src2;
            BR_BEQ,
            BR_BNE,
            BR_BLT,
            BR_BGE,
            BR_BLTU,
            BR_BGEU: target = issue.pc + issue.imm;
            default: target = '0;
        endcase
    end

endmodule

// ==== src/exe_stage_reg.sv ====
`timescale 1ns/10ps
`include "exe_macros.svh"

module exe_stage_reg
    import exe_op_pkg::*;
    import exe_mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue_vld,
    input  exe_issue_t            issue,
    input  exe_result_t           result,
    input  logic                  taken,
    input  logic [`XLEN-1:0]      target,
    input  logic                  lsu_rdy,
    output logic                  br_vld,
    output logic [`BR_ADDR_W-1:0] br_addr,
    output logic                  lsu_vld,
    output exe_lsu_req_t          lsu_req,
    output exe_fwd_t              fwd
);

    logic                       accept;
    logic                       ld_st;
    sram_addr_u                 mem_addr_u;
    sram_bank_e                 bank_nxt;
    logic                       wb_vld_q;
    logic [`REG_ADDR_W-1:0]     wb_addr_q;
    logic [`XLEN-1:0]           wb_data_q;
    mem_op_e                    mem_op_q;
    sram_bank_e                 bank_q;
    logic [`SRAM_ADDR_SIZE-1:0] offset_q;
    logic [`XLEN-1:0]           st_data_q;

    // drop anything arriving behind a taken redirect
    assign accept = issue_vld & lsu_rdy & ~br_vld;

    assign ld_st          = is_load(issue.mem_op) | is_store(issue.mem_op);
    assign mem_addr_u.raw = result.mem_addr;
    assign bank_nxt       = ld_st ? mem_addr_u.fields.bank : BANK_NONE;

    // valid flags only move when lsu can take them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            br_vld   <= 1'b0;
            lsu_vld  <= 1'b0;
            wb_vld_q <= 1'b0;
        end else if (lsu_rdy) begin
            br_vld   <= accept & taken;
            lsu_vld  <= accept & ~result.is_branch_op;
            wb_vld_q <= accept & issue.wb_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            br_addr   <= target[`BR_ADDR_W-1:0];
            wb_addr_q <= issue.wb_addr;
            wb_data_q <= result.wb_data;
            mem_op_q  <= issue.mem_op;
            bank_q    <= bank_nxt;
            offset_q  <= mem_addr_u.fields.offset;
            st_data_q <= issue.src2;
        end
    end

    assign lsu_req = '{wb_vld: wb_vld_q, wb_addr: wb_addr_q, wb_data: wb_data_q,
                       mem_op: mem_op_q, bank: bank_q, offset: offset_q,
                       st_data: st_data_q};

    // same-cycle bypass to decode
    assign fwd.vld  = accept & issue.wb_vld;
    assign fwd.ld   = is_load(issue.mem_op);
    assign fwd.addr = issue.wb_addr;
    assign fwd.data = result.wb_data;

endmodule

// ==== src/exe_top.sv ====
`timescale 1ns/10ps
`include "exe_macros.svh"

module exe_top
    import exe_op_pkg::*;
    import exe_mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue_vld,
    input  exe_issue_t            issue,
    input  logic                  lsu_rdy,
    output logic                  idu_rdy,
    output logic                  flush_vld,
    output exe_fwd_t              fwd,
    output logic                  br_vld,
    output logic [`BR_ADDR_W-1:0] br_addr,
    output logic                  lsu_vld,
    output exe_lsu_req_t          lsu_req
);

    exe_result_t      result;
    logic             taken;
    logic [`XLEN-1:0] target;

    assign idu_rdy   = lsu_rdy;
    assign flush_vld = br_vld;

    exe_int_alu int_alu0 (
        .issue  (issue),
        .result (result)
    );

    exe_branch branch0 (
        .issue  (issue),
        .taken  (taken),
        .target (target)
    );

    exe_stage_reg stage_reg0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue_vld (issue_vld),
        .issue     (issue),
        .result    (result),
        .taken     (taken),
        .target    (target),
        .lsu_rdy   (lsu_rdy),
        .br_vld    (br_vld),
        .br_addr   (br_addr),
        .lsu_vld   (lsu_vld),
        .lsu_req   (lsu_req),
        .fwd       (fwd)
    );

endmodule

// ==== verification/exe_properties.sv ====
`timescale 1ns/10ps
`include "exe_macros.svh"

module exe_properties
    import exe_mem_pkg::*;
(
    input logic                  clk,
    input logic                  rst_n,
    input logic                  lsu_rdy,
    input logic                  br_vld,
    input logic                  lsu_vld,
    input logic [`BR_ADDR_W-1:0] br_addr,
    input exe_lsu_req_t          lsu_req
);

    reset_clears: assert property (@(posedge clk) !rst_n |=> !br_vld && !lsu_vld)
        else $error("br_vld or lsu_vld high coming out of reset");

    // stalled edge leaves every registered output alone
    stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
        !lsu_rdy |=> br_vld == $past(br_vld) && lsu_vld == $past(lsu_vld)
                     && br_addr == $past(br_addr) && lsu_req == $past(lsu_req))
        else $error("stage outputs moved while lsu_rdy was low");

    flush_drops: assert property (@(posedge clk) disable iff (!rst_n)
        br_vld && lsu_rdy |=> !br_vld && !lsu_vld)
        else $error("issue taken while a redirect was pending");

endmodule

bind exe_stage_reg exe_properties props0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .lsu_rdy (lsu_rdy),
    .br_vld  (br_vld),
    .lsu_vld (lsu_vld),
    .br_addr (br_addr),
    .lsu_req (lsu_req)
);

// ==== verification/exe_tb.sv ====
`timescale 1ns/10ps
`include "exe_macros.svh"

module exe_tb
    import exe_op_pkg::*;
    import exe_mem_pkg::*;
();

    localparam int ACCEPT_TIMEOUT = 20;

    logic                  clk;
    logic                  rst_n;
    logic                  issue_vld;
    exe_issue_t            issue;
    logic                  lsu_rdy;
    logic                  idu_rdy;
    logic                  flush_vld;
    exe_fwd_t              fwd;
    logic                  br_vld;
    logic [`BR_ADDR_W-1:0] br_addr;
    logic                  lsu_vld;
    exe_lsu_req_t          lsu_req;
    logic [31:0]           seed;
    int                    err_cnt;
    int                    test_cnt;

    exe_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .issue_vld (issue_vld),
        .issue     (issue),
        .lsu_rdy   (lsu_rdy),
        .idu_rdy   (idu_rdy),
        .flush_vld (flush_vld),
        .fwd       (fwd),
        .br_vld    (br_vld),
        .br_addr   (br_addr),
        .lsu_vld   (lsu_vld),
        .lsu_req   (lsu_req)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic exe_issue_t make_issue(input alu_op_e alu, input br_op_e br,
                                              input mem_op_e mem, input logic [`XLEN-1:0] a,
                                              input logic [`XLEN-1:0] b,
                                              input logic [`XLEN-1:0] imm,
                                              input logic [`XLEN-1:0] pc);
        exe_issue_t t;
        t.alu_op  = alu;
        t.br_op   = br;
        t.mem_op  = mem;
        t.wb_vld  = 1'b1;
        t.wb_addr = a[`REG_ADDR_W-1:0];
        t.src1    = a;
        t.src2    = b;
        t.imm     = imm;
        t.pc      = pc;
        return t;
    endfunction

    // reference results straight from the isa rules
    function automatic logic [`XLEN-1:0] alu_ref(input exe_issue_t t);
        case (t.alu_op)
            ALU_ADD:   return t.src1 + t.src2;
            ALU_SUB:   return t.src1 - t.src2;
            ALU_SLT:   return 32'($signed(t.src1) < $signed(t.src2));
            ALU_SLTU:  return 32'(t.src1 < t.src2);
            ALU_XOR:   return t.src1 ^ t.src2;
            ALU_OR:    return t.src1 | t.src2;
            ALU_AND:   return t.src1 & t.src2;
            ALU_SLL:   return t.src1 << t.src2[4:0];
            ALU_SRL:   return t.src1 >> t.src2[4:0];
            ALU_SRA:   return $signed(t.src1) >>> t.src2[4:0];
            ALU_LUI:   return t.src2;
            ALU_AUIPC: return t.pc + t.src2;
            ALU_LINK:  return t.pc + `PC_STEP;
            default:   return '0;
        endcase
    endfunction

    function automatic logic branch_ref(input exe_issue_t t);
        case (t.br_op)
            BR_BEQ:  return t.src1 == t.src2;
            BR_BNE:  return t.src1 != t.src2;
            BR_BLT:  return $signed(t.src1) < $signed(t.src2);
            BR_BGE:  return $signed(t.src1) >= $signed(t.src2);
            BR_BLTU: return t.src1 < t.src2;
            BR_BGEU: return t.src1 >= t.src2;
            default: return 1'b1;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        err_cnt++;
    endtask

    task automatic finish_test(input string name, input int errs_before);
        $display("%s: %0d errors", name, err_cnt - errs_before);
        test_cnt++;
    endtask

    task automatic present(input exe_issue_t t);
        @(posedge clk);
        issue_vld <= 1'b1;
        issue     <= t;
    endtask

    // returns at the negedge before the accepting edge
    task automatic wait_accept();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(idu_rdy && !flush_vld) && cycles < ACCEPT_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= ACCEPT_TIMEOUT) begin
            $display("timeout at %0t: the issue was never accepted", $time);
            err_cnt++;
        end
    endtask

    task automatic check_fwd(input exe_issue_t t);
        logic exp_ld;
        exp_ld = t.mem_op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
        if (fwd.vld !== t.wb_vld) report_mismatch("fwd.vld", 32'(fwd.vld), 32'(t.wb_vld));
        if (fwd.ld !== exp_ld) report_mismatch("fwd.ld", 32'(fwd.ld), 32'(exp_ld));
        if (fwd.addr !== t.wb_addr)
            report_mismatch("fwd.addr", 32'(fwd.addr), 32'(t.wb_addr));
        if (fwd.data !== alu_ref(t)) report_mismatch("fwd.data", fwd.data, alu_ref(t));
    endtask

    task automatic retire();
        @(posedge clk);
        issue_vld <= 1'b0;
        @(negedge clk);
    endtask

    task automatic run_issue(input exe_issue_t t);
        present(t);
        wait_accept();
        check_fwd(t);
        retire();
        if (lsu_req.wb_vld !== t.wb_vld)
            report_mismatch("lsu_req.wb_vld", 32'(lsu_req.wb_vld), 32'(t.wb_vld));
        if (lsu_req.wb_addr !== t.wb_addr)
            report_mismatch("lsu_req.wb_addr", 32'(lsu_req.wb_addr), 32'(t.wb_addr));
    endtask

    task automatic test_arith();
        int         errs;
        exe_issue_t t;
        errs = err_cnt;
        for (int op = ALU_ADD; op <= ALU_LINK; op++) begin
            for (int n = 0; n < 4; n++) begin
                t = make_issue(alu_op_e'(op), BR_NONE, MEM_NONE, next_rand(), next_rand(),
                               32'h0, next_rand());
                run_issue(t);
                if (lsu_vld !== 1'b1) report_mismatch("lsu_vld", 32'(lsu_vld), 32'd1);
                if (br_vld !== 1'b0) report_mismatch("br_vld", 32'(br_vld), 32'd0);
                if (lsu_req.wb_data !== alu_ref(t))
                    report_mismatch("lsu_req.wb_data", lsu_req.wb_data, alu_ref(t));
                if (lsu_req.bank !== BANK_NONE)
                    report_mismatch("lsu_req.bank", 32'(lsu_req.bank), 32'(BANK_NONE));
                if (lsu_req.offset !== '0)
                    report_mismatch("lsu_req.offset", 32'(lsu_req.offset), 32'd0);
            end
        end
        finish_test("arithmetic", errs);
    endtask

    task automatic test_branch();
        int               errs;
        exe_issue_t       t;
        logic [`XLEN-1:0] a_list [4];
        logic [`XLEN-1:0] b_list [4];
        logic [`XLEN-1:0] tgt;
        errs = err_cnt;
        a_list[0] = next_rand();
        b_list[0] = a_list[0];
        // both positive, unsigned-only less, signed-only less
        a_list[1] = 32'd100;
        b_list[1] = 32'd2000;
        a_list[2] = 32'd3;
        b_list[2] = 32'hffff_fffb;
        a_list[3] = 32'hffff_fffb;
        b_list[3] = 32'd3;
        for (int op = BR_BEQ; op <= BR_BGEU; op++) begin
            for (int p = 0; p < 4; p++) begin
                t = make_issue(ALU_NONE, br_op_e'(op), MEM_NONE, a_list[p], b_list[p],
                               next_rand(), next_rand());
                t.wb_vld = 1'b0;
                tgt = t.pc + t.imm;
                run_issue(t);
                if (br_vld !== branch_ref(t))
                    report_mismatch("br_vld", 32'(br_vld), 32'(branch_ref(t)));
                if (lsu_vld !== 1'b0) report_mismatch("lsu_vld", 32'(lsu_vld), 32'd0);
                if (br_vld && br_addr !== tgt[`BR_ADDR_W-1:0])
                    report_mismatch("br_addr", 32'(br_addr), 32'(tgt[`BR_ADDR_W-1:0]));
            end
        end
        // issue offered behind a taken branch must be dropped
        t = make_issue(ALU_NONE, BR_BEQ, MEM_NONE, 32'd9, 32'd9, 32'h40, 32'h100);
        t.wb_vld = 1'b0;
        present(t);
        wait_accept();
        present(make_issue(ALU_ADD, BR_NONE, MEM_NONE, 32'd1, 32'd2, 32'h0, 32'h0));
        @(negedge clk);
        if (flush_vld !== 1'b1) report_mismatch("flush_vld", 32'(flush_vld), 32'd1);
        if (fwd.vld !== 1'b0) report_mismatch("fwd.vld", 32'(fwd.vld), 32'd0);
        retire();
        if (lsu_vld !== 1'b0) report_mismatch("lsu_vld", 32'(lsu_vld), 32'd0);
        finish_test("branch", errs);
    endtask

    task automatic test_jump();
        int               errs;
        exe_issue_t       t;
        logic [`XLEN-1:0] tgt;
        errs = err_cnt;
        for (int op = BR_JAL; op <= BR_JALR; op++) begin
            for (int n = 0; n < 3; n++) begin
                t = make_issue(ALU_LINK, br_op_e'(op), MEM_NONE, next_rand(), next_rand(),
                               32'h0, next_rand());
                tgt = (op == BR_JAL) ? t.pc + t.src2 : t.src1 + t.src2;
                run_issue(t);
                if (br_vld !== 1'b1) report_mismatch("br_vld", 32'(br_vld), 32'd1);
                if (lsu_vld !== 1'b1) report_mismatch("lsu_vld", 32'(lsu_vld), 32'd1);
                if (br_addr !== tgt[`BR_ADDR_W-1:0])
                    report_mismatch("br_addr", 32'(br_addr), 32'(tgt[`BR_ADDR_W-1:0]));
                if (lsu_req.wb_data !== t.pc + 32'd4)
                    report_mismatch("lsu_req.wb_data", lsu_req.wb_data, t.pc + 32'd4);
            end
        end
        finish_test("jump", errs);
    endtask

    task automatic test_mem();
        int               errs;
        exe_issue_t       t;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] d;
        logic             load;
        errs = err_cnt;
        for (int op = MEM_LB; op <= MEM_SW; op++) begin
            for (int bk = 0; bk < 4; bk++) begin
                addr = next_rand();
                addr[`SRAM_ADDR_SIZE +: `SRAM_BANK_W] = bk[1:0];
                a = next_rand();
                d = next_rand();
                load = mem_op_e'(op) inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
                if (load) begin
                    t = make_issue(ALU_NONE, BR_NONE, mem_op_e'(op), a, addr - a, 32'h0, 32'h0);
                end else begin
                    t = make_issue(ALU_NONE, BR_NONE, mem_op_e'(op), a, d, addr - a, 32'h0);
                    t.wb_vld = 1'b0;
                end
                run_issue(t);
                if (lsu_vld !== 1'b1) report_mismatch("lsu_vld", 32'(lsu_vld), 32'd1);
                if (lsu_req.bank !== bk[1:0])
                    report_mismatch("lsu_req.bank", 32'(lsu_req.bank), 32'(bk[1:0]));
                if (lsu_req.offset !== addr[`SRAM_ADDR_SIZE-1:0])
                    report_mismatch("lsu_req.offset", 32'(lsu_req.offset),
                                    32'(addr[`SRAM_ADDR_SIZE-1:0]));
                if (lsu_req.mem_op !== t.mem_op)
                    report_mismatch("lsu_req.mem_op", 32'(lsu_req.mem_op), 32'(t.mem_op));
                if (!load && lsu_req.st_data !== d)
                    report_mismatch("lsu_req.st_data", lsu_req.st_data, d);
            end
        end
        finish_test("load store", errs);
    endtask

    task automatic test_backpressure();
        int           errs;
        exe_issue_t   op1;
        exe_issue_t   op2;
        exe_lsu_req_t snap_req;
        errs = err_cnt;
        op1 = make_issue(ALU_ADD, BR_NONE, MEM_NONE, next_rand(), next_rand(), 32'h0, 32'h0);
        op2 = make_issue(ALU_XOR, BR_NONE, MEM_NONE, next_rand(), next_rand(), 32'h0, 32'h0);
        present(op1);
        wait_accept();
        check_fwd(op1);
        // stall starts on the edge that takes op1
        @(posedge clk);
        lsu_rdy <= 1'b0;
        issue   <= op2;
        @(negedge clk);
        snap_req = lsu_req;
        if (lsu_req.wb_data !== alu_ref(op1))
            report_mismatch("lsu_req.wb_data", lsu_req.wb_data, alu_ref(op1));
        repeat (3) begin
            if (idu_rdy !== 1'b0) report_mismatch("idu_rdy", 32'(idu_rdy), 32'd0);
            if (fwd.vld !== 1'b0) report_mismatch("fwd.vld", 32'(fwd.vld), 32'd0);
            if (lsu_vld !== 1'b1) report_mismatch("lsu_vld", 32'(lsu_vld), 32'd1);
            if (lsu_req !== snap_req) begin
                $display("Fail at %0t: lsu_req got %h expected %h", $time, lsu_req, snap_req);
                err_cnt++;
            end
            @(negedge clk);
        end
        @(posedge clk);
        lsu_rdy <= 1'b1;
        wait_accept();
        check_fwd(op2);
        retire();
        if (lsu_req.wb_data !== alu_ref(op2))
            report_mismatch("lsu_req.wb_data", lsu_req.wb_data, alu_ref(op2));
        finish_test("back-pressure", errs);
    endtask

    initial begin
        seed      = 32'd29;
        err_cnt   = 0;
        test_cnt  = 0;
        rst_n     <= 1'b0;
        issue_vld <= 1'b0;
        issue     <= '0;
        lsu_rdy   <= 1'b1;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (lsu_vld !== 1'b0) report_mismatch("lsu_vld", 32'(lsu_vld), 32'd0);
        if (br_vld !== 1'b0) report_mismatch("br_vld", 32'(br_vld), 32'd0);
        if (lsu_req.wb_vld !== 1'b0)
            report_mismatch("lsu_req.wb_vld", 32'(lsu_req.wb_vld), 32'd0);
        test_arith();
        test_branch();
        test_jump();
        test_mem();
        test_backpressure();
        $display("tests run %0d, errors %0d", test_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+include
src/exe_op_pkg.sv
src/exe_mem_pkg.sv
src/exe_int_alu.sv
src/exe_branch.sv
src/exe_stage_reg.sv
src/exe_top.sv
verification/exe_properties.sv
verification/exe_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := exe_tb
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Regression passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
